//--- verilog/bf_config.svh
// Beamformer configuration: channel count, widths, rounding shift and pipeline latencies
`ifndef BF_CONFIG_SVH
`define BF_CONFIG_SVH

// Number of antenna channels summed into one beam
`define NUM_CH 4

// Component widths of samples, weights and rounded products
`define SAMPLE_W 16
`define WEIGHT_W 16
`define PROD_W 16

// Fractional bits dropped after the complex multiply (Q1.15 weights)
`define FRAC_BITS 15

// Beam component width, two guard bits for a four-way sum
`define BEAM_W (`PROD_W + 2)

// Latencies in clock cycles
`define CMULT_LAT 7
`define TOP_LAT 9

`endif

//--- verilog/bf_pkg.sv
// Beamformer package: vector types shared by the datapath and the testbench
`include "bf_config.svh"

package bf_pkg;

  // ******************************
  // Datapath component types
  // ******************************

  // One real or imaginary part of an input sample
  typedef logic signed [`SAMPLE_W-1:0] sample_t;

  // One real or imaginary part of a complex weight
  typedef logic signed [`WEIGHT_W-1:0] weight_t;

  // Rounded product component from a channel multiplier
  typedef logic signed [`PROD_W-1:0] prod_t;

  // Beam output component, full width sum of all products
  typedef logic signed [`BEAM_W-1:0] beam_t;

  // Channel index, one bit wider so an out of range index is visible
  typedef logic [$clog2(`NUM_CH + 1)-1:0] ch_idx_t;

endpackage

//--- verilog/bf_chan_if.sv
// Per-channel feed link: registered sample, active weight and valid strobe
`timescale 1ns/1ps

interface bf_chan_if;

  // Complex input sample for this channel
  bf_pkg::sample_t s_re;
  bf_pkg::sample_t s_im;

  // Active complex weight paired with the sample
  bf_pkg::weight_t w_re;
  bf_pkg::weight_t w_im;

  // One-cycle strobe per sample
  logic valid;

  // Weight bank side
  modport feed (
    output s_re, s_im, w_re, w_im, valid
  );

  // Multiplier side
  modport mult (
    input s_re, s_im, w_re, w_im, valid
  );

endinterface

//--- verilog/bf_prod_if.sv
// Per-channel product link: rounded complex product, overflow flag and valid strobe
`timescale 1ns/1ps

interface bf_prod_if;

  // Rounded complex product
  bf_pkg::prod_t p_re;
  bf_pkg::prod_t p_im;

  // Set when either component did not fit the product width
  logic ovf;

  // Strobe delayed alongside the data
  logic valid;

  // Multiplier side
  modport mult (
    output p_re, p_im, ovf, valid
  );

  // Combiner side
  modport comb (
    input p_re, p_im, ovf, valid
  );

endinterface

//--- verilog/weight_bank.sv
// Weight bank: shadow/active complex weights and sample input register per channel
`timescale 1ns/1ps
`include "bf_config.svh"

module weight_bank (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             in_valid,
  input  bf_pkg::sample_t [`NUM_CH-1:0]    in_re,
  input  bf_pkg::sample_t [`NUM_CH-1:0]    in_im,
  input  logic                             wr_en,
  input  bf_pkg::ch_idx_t                  wr_ch,
  input  bf_pkg::weight_t                  wr_re,
  input  bf_pkg::weight_t                  wr_im,
  input  logic                             commit,
  bf_chan_if.feed                          ch [`NUM_CH]
);

  // Weights written by the host, not yet in use
  bf_pkg::weight_t [`NUM_CH-1:0] shadow_re, shadow_im;
  // Weights applied to incoming samples
  bf_pkg::weight_t [`NUM_CH-1:0] active_re, active_im;
  // Sample register and the weight captured with it
  bf_pkg::sample_t [`NUM_CH-1:0] smp_re, smp_im;
  bf_pkg::weight_t [`NUM_CH-1:0] wgt_re, wgt_im;
  logic                          valid_q;

  // ******************************
  // Shadow and active banks
  // ******************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shadow_re <= '0;
      shadow_im <= '0;
      active_re <= '0;
      active_im <= '0;
    end else begin
      for (int c = 0; c < `NUM_CH; c++) begin
        if (wr_en && wr_ch == bf_pkg::ch_idx_t'(c)) begin
          shadow_re[c] <= wr_re;
          shadow_im[c] <= wr_im;
        end
      end
      // Commit sees the shadow bank from before a same-cycle write
      if (commit) begin
        active_re <= shadow_re;
        active_im <= shadow_im;
      end
    end
  end

  // Valid strobe, one cycle behind in_valid
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  // Sample and weight captured on the same edge
  // A sample in the commit cycle still picks up the old active set
  always_ff @(posedge clk) begin
    smp_re <= in_re;
    smp_im <= in_im;
    wgt_re <= active_re;
    wgt_im <= active_im;
  end

  // Fan out to the channel links
  for (genvar c = 0; c < `NUM_CH; c++) begin : g_feed
    assign ch[c].s_re  = smp_re[c];
    assign ch[c].s_im  = smp_im[c];
    assign ch[c].w_re  = wgt_re[c];
    assign ch[c].w_im  = wgt_im[c];
    assign ch[c].valid = valid_q;
  end

  // Host must address an existing channel
  a_wr_ch_range: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> wr_ch < `NUM_CH);

endmodule

//--- verilog/cmult.sv
// Complex multiplier: three real multipliers, rounding to PROD_W and overflow flag
`timescale 1ns/1ps
`include "bf_config.svh"

module cmult (
  input  logic     clk,
  input  logic     rst_n,
  bf_chan_if.mult  a,
  bf_prod_if.mult  p
);

  // Full precision width of a product term
  localparam int FULL_W = `SAMPLE_W + `WEIGHT_W + 1;
  // Lowest bit that must match the sign for the result to fit
  localparam int SIGN_LO = `PROD_W + `FRAC_BITS - 1;
  // Half an output LSB
  localparam logic signed [FULL_W-1:0] RND = 1 << (`FRAC_BITS - 1);

  // Operand delay taps
  bf_pkg::sample_t ar_d, ar_dd, ar_ddd, ar_dddd;
  bf_pkg::sample_t ai_d, ai_dd, ai_ddd, ai_dddd;
  bf_pkg::weight_t br_d, br_dd, br_ddd;
  bf_pkg::weight_t bi_d, bi_dd, bi_ddd;

  // Pre-adders, products and sums
  logic signed [`SAMPLE_W:0] add_common;
  logic signed [`WEIGHT_W:0] add_re, add_im;
  logic signed [FULL_W-1:0]  mult_common, mult_re, mult_im;
  logic signed [FULL_W-1:0]  common, common_re, common_im;
  logic signed [FULL_W-1:0]  sum_re, sum_im;

  // Output registers
  bf_pkg::prod_t            p_re_q, p_im_q;
  logic                     ovf_q;
  logic [`CMULT_LAT-1:0]    vld_sr;

  // Delay taps, the first stage is the input register
  always_ff @(posedge clk) begin
    ar_d    <= a.s_re;
    ar_dd   <= ar_d;
    ar_ddd  <= ar_dd;
    ar_dddd <= ar_ddd;
    ai_d    <= a.s_im;
    ai_dd   <= ai_d;
    ai_ddd  <= ai_dd;
    ai_dddd <= ai_ddd;
    br_d    <= a.w_re;
    br_dd   <= br_d;
    br_ddd  <= br_dd;
    bi_d    <= a.w_im;
    bi_dd   <= bi_d;
    bi_ddd  <= bi_dd;
  end

  // ******************************
  // Common term (ar - ai) * bi
  // ******************************
  // Rounding constant folded in here so both paths get it once
  always_ff @(posedge clk) begin
    add_common  <= ar_d - ai_d;
    mult_common <= add_common * bi_dd;
    common      <= mult_common + RND;
    // One copy per path
    common_re   <= common;
    common_im   <= common;
  end

  // Real part: ar * (br - bi) + common = ar*br - ai*bi
  always_ff @(posedge clk) begin
    add_re  <= br_ddd - bi_ddd;
    mult_re <= add_re * ar_dddd;
    sum_re  <= mult_re + common_re;
  end

  // Imaginary part: ai * (br + bi) + common = ai*br + ar*bi
  always_ff @(posedge clk) begin
    add_im  <= br_ddd + bi_ddd;
    mult_im <= add_im * ai_dddd;
    sum_im  <= mult_im + common_im;
  end

  // ******************************
  // Slice and overflow check
  // ******************************
  always_ff @(posedge clk) begin
    p_re_q <= sum_re[`PROD_W+`FRAC_BITS-1:`FRAC_BITS];
    p_im_q <= sum_im[`PROD_W+`FRAC_BITS-1:`FRAC_BITS];
    // Bits above the slice must all copy the sign
    ovf_q  <= !(&sum_re[FULL_W-1:SIGN_LO] || !(|sum_re[FULL_W-1:SIGN_LO])) ||
              !(&sum_im[FULL_W-1:SIGN_LO] || !(|sum_im[FULL_W-1:SIGN_LO]));
  end

  // Valid travels the same CMULT_LAT stages as the data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[`CMULT_LAT-2:0], a.valid};
    end
  end

  assign p.p_re  = p_re_q;
  assign p.p_im  = p_im_q;
  assign p.ovf   = ovf_q;
  assign p.valid = vld_sr[`CMULT_LAT-1];

  // The valid chain must be clean once reset has been released
  a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(p.valid));

endmodule

//--- verilog/beam_combiner.sv
// Beam combiner: registered full-width sum of all channel products and OR of overflows
`timescale 1ns/1ps
`include "bf_config.svh"

module beam_combiner (
  input  logic           clk,
  input  logic           rst_n,
  bf_prod_if.comb        p [`NUM_CH],
  output bf_pkg::beam_t  beam_re,
  output bf_pkg::beam_t  beam_im,
  output logic           ovf,
  output logic           out_valid
);

  // Products gathered from the links
  bf_pkg::prod_t [`NUM_CH-1:0] prod_re, prod_im;
  logic [`NUM_CH-1:0]          ovf_vec;
  logic [`NUM_CH-1:0]          valid_vec;

  // Combinational sums
  bf_pkg::beam_t sum_re, sum_im;

  for (genvar c = 0; c < `NUM_CH; c++) begin : g_tap
    assign prod_re[c]   = p[c].p_re;
    assign prod_im[c]   = p[c].p_im;
    assign ovf_vec[c]   = p[c].ovf;
    assign valid_vec[c] = p[c].valid;
  end

  // ******************************
  // Adder tree
  // ******************************
  // Sign extend before adding, two guard bits cover four terms
  always_comb begin
    sum_re = '0;
    sum_im = '0;
    for (int c = 0; c < `NUM_CH; c++) begin
      sum_re = sum_re + bf_pkg::beam_t'(prod_re[c]);
      sum_im = sum_im + bf_pkg::beam_t'(prod_im[c]);
    end
  end

  // Beam data register
  always_ff @(posedge clk) begin
    beam_re <= sum_re;
    beam_im <= sum_im;
    ovf     <= |ovf_vec;
  end

  // Channel 0 stands for all channels
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= valid_vec[0];
    end
  end

  // All multipliers run in lockstep
  a_valid_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    (&valid_vec) || !(|valid_vec));

endmodule

//--- verilog/beamformer_top.sv
// Four-channel narrowband beamformer: weight bank, per-channel complex multipliers, combiner
`timescale 1ns/1ps
`include "bf_config.svh"

module beamformer_top (
  input  logic                           clk,
  input  logic                           rst_n,
  // Sample input, one complex value per channel
  input  logic                           in_valid,
  input  bf_pkg::sample_t [`NUM_CH-1:0]  in_re,
  input  bf_pkg::sample_t [`NUM_CH-1:0]  in_im,
  // Weight write port
  input  logic                           wr_en,
  input  bf_pkg::ch_idx_t                wr_ch,
  input  bf_pkg::weight_t                wr_re,
  input  bf_pkg::weight_t                wr_im,
  input  logic                           commit,
  // Beam output, TOP_LAT cycles after in_valid
  output bf_pkg::beam_t                  beam_re,
  output bf_pkg::beam_t                  beam_im,
  output logic                           ovf,
  output logic                           out_valid
);

  // Links between the stages
  bf_chan_if chan [`NUM_CH] ();
  bf_prod_if prod [`NUM_CH] ();

  // ******************************
  // Weight bank, 1 cycle
  // ******************************
  weight_bank u_bank (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_re    (in_re),
    .in_im    (in_im),
    .wr_en    (wr_en),
    .wr_ch    (wr_ch),
    .wr_re    (wr_re),
    .wr_im    (wr_im),
    .commit   (commit),
    .ch       (chan)
  );

  // One multiplier per channel, CMULT_LAT cycles
  for (genvar c = 0; c < `NUM_CH; c++) begin : g_ch
    cmult u_cmult (
      .clk   (clk),
      .rst_n (rst_n),
      .a     (chan[c]),
      .p     (prod[c])
    );
  end

  // Combiner, 1 cycle
  beam_combiner u_comb (
    .clk       (clk),
    .rst_n     (rst_n),
    .p         (prod),
    .beam_re   (beam_re),
    .beam_im   (beam_im),
    .ovf       (ovf),
    .out_valid (out_valid)
  );

endmodule

//--- verification/beamformer_tb.sv
// Beamformer testbench: trace file stimulus with queued expected beam results
`timescale 1ns/1ps
`include "bf_config.svh"

module beamformer_tb;

  logic                          clk;
  logic                          rst_n;
  logic                          in_valid;
  bf_pkg::sample_t [`NUM_CH-1:0] in_re;
  bf_pkg::sample_t [`NUM_CH-1:0] in_im;
  logic                          wr_en;
  bf_pkg::ch_idx_t               wr_ch;
  bf_pkg::weight_t               wr_re;
  bf_pkg::weight_t               wr_im;
  logic                          commit;
  bf_pkg::beam_t                 beam_re;
  bf_pkg::beam_t                 beam_im;
  logic                          ovf;
  logic                          out_valid;

  // Expected results in issue order
  bf_pkg::beam_t exp_re_q[$];
  bf_pkg::beam_t exp_im_q[$];
  logic          exp_ovf_q[$];

  // Trace commands without comment lines
  string  trace[$];
  integer seed;
  bit     gaps_on;
  int     cycles;
  int     limit;
  int     results;

  beamformer_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_re     (in_re),
    .in_im     (in_im),
    .wr_en     (wr_en),
    .wr_ch     (wr_ch),
    .wr_re     (wr_re),
    .wr_im     (wr_im),
    .commit    (commit),
    .beam_re   (beam_re),
    .beam_im   (beam_im),
    .ovf       (ovf),
    .out_valid (out_valid)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // ******************************
  // Error helpers and compares
  // ******************************
  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "Beamformer check failed");
  endtask

  task automatic check_beam(input string name, input bf_pkg::beam_t got,
                            input bf_pkg::beam_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("Fail at %0t ns: %s got %h expected %h",
                                $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("Fail at %0t ns: %s got %b expected %b",
                                $time, name, got, exp));
    end
  endtask

  // Cycle budget from the trace length
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      stop_with_error($sformatf("Timeout after %0d cycles with %0d results pending",
                                cycles, exp_re_q.size()));
    end
  end

  // Outputs sampled mid-cycle away from the driving edge
  always @(negedge clk) begin
    if (cycles > 0 && $isunknown(out_valid)) begin
      stop_with_error($sformatf("out_valid is unknown at %0t ns", $time));
    end else if (out_valid === 1'b1) begin
      if (exp_re_q.size() == 0) begin
        stop_with_error($sformatf("out_valid at %0t ns with no sample outstanding", $time));
      end else begin
        check_beam("beam_re", beam_re, exp_re_q.pop_front());
        check_beam("beam_im", beam_im, exp_im_q.pop_front());
        check_flag("ovf", ovf, exp_ovf_q.pop_front());
        results = results + 1;
      end
    end
  end

  // ******************************
  // Stimulus
  // ******************************
  task automatic read_trace();
    int    fd;
    int    n;
    string line;
    fd = $fopen("verification/beamformer_trace.txt", "r");
    if (fd == 0) begin
      stop_with_error("Cannot open verification/beamformer_trace.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        // Skip blank lines and comments
        if (n > 1 && line.getc(0) != "#") begin
          trace.push_back(line);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_idle(input int n);
    repeat (n) begin
      @(posedge clk);
      in_valid <= 1'b0;
      wr_en    <= 1'b0;
      commit   <= 1'b0;
    end
  endtask

  task automatic run_line(input string line);
    byte             kind;
    string           args;
    int              n;
    int              num;
    int              ov;
    bf_pkg::weight_t w_re, w_im;
    bf_pkg::sample_t sr0, si0, sr1, si1, sr2, si2, sr3, si3;
    bf_pkg::beam_t   b_re, b_im;
    kind = line.getc(0);
    args = line.substr(2, line.len() - 1);
    if (kind == "I") begin
      n = $sscanf(args, "%d", num);
      drive_idle(num);
    end else if (kind == "R") begin
      n = $sscanf(args, "%d", num);
      gaps_on = (num != 0);
    end else begin
      @(posedge clk);
      in_valid <= 1'b0;
      wr_en    <= 1'b0;
      commit   <= 1'b0;
      if (kind == "W") begin
        n = $sscanf(args, "%d %h %h", num, w_re, w_im);
        wr_en <= 1'b1;
        wr_ch <= bf_pkg::ch_idx_t'(num);
        wr_re <= w_re;
        wr_im <= w_im;
      end else if (kind == "C") begin
        commit <= 1'b1;
      end else if (kind == "S") begin
        n = $sscanf(args, "%h %h %h %h %h %h %h %h %h %h %h",
                    sr0, si0, sr1, si1, sr2, si2, sr3, si3, b_re, b_im, ov);
        if (n != 11) begin
          stop_with_error($sformatf("Malformed sample line in trace: %s", line));
        end else begin
          in_valid <= 1'b1;
          in_re    <= {sr3, sr2, sr1, sr0};
          in_im    <= {si3, si2, si1, si0};
          exp_re_q.push_back(b_re);
          exp_im_q.push_back(b_im);
          exp_ovf_q.push_back(ov[0]);
          // Optional gap of 0 to 2 idle cycles
          if (gaps_on) begin
            drive_idle({$random(seed)} % 3);
          end
        end
      end else begin
        stop_with_error($sformatf("Unknown trace command: %s", line));
      end
    end
  endtask

  initial begin
    seed     = 67;
    gaps_on  = 1'b0;
    cycles   = 0;
    results  = 0;
    limit    = 1000;
    clk      = 1'b0;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_re    = '0;
    in_im    = '0;
    wr_en    = 1'b0;
    wr_ch    = '0;
    wr_re    = '0;
    wr_im    = '0;
    commit   = 1'b0;
    read_trace();
    limit = 4 * trace.size() + `TOP_LAT + 100;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    foreach (trace[i]) begin
      run_line(trace[i]);
    end
    // Drain the pipeline
    // A stray out_valid here has no sample behind it
    drive_idle(`TOP_LAT + 2);
    if (exp_re_q.size() != 0) begin
      stop_with_error($sformatf("%0d expected results never appeared", exp_re_q.size()));
    end else begin
      $display("Checked %0d beam results", results);
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

//--- list.f
+incdir+verilog
verilog/bf_pkg.sv
verilog/bf_chan_if.sv
verilog/bf_prod_if.sv
verilog/weight_bank.sv
verilog/cmult.sv
verilog/beam_combiner.sv
verilog/beamformer_top.sv
verification/beamformer_tb.sv

//--- Makefile
# Verilator build and run of the beamformer testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f list.f --top-module beamformer_tb -Mdir obj_dir
	./obj_dir/Vbeamformer_tb | tee sim.log
	@grep -q 'All tests passed!' sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/beamformer_trace.txt
# Commands: W ch w_re w_im | C | S re0 im0 re1 im1 re2 im2 re3 im3 beam_re beam_im ovf
# I n idles n cycles, R 1 or R 0 turns random gaps after S on or off, data in hex
I 2
# Unit weight on channel 0, other channels zero
W 0 7fff 0000
C
R 1
S 1000 e000 1234 5678 7fff 8000 0001 ffff 01000 3e000 0
S 7530 8ad0 8000 8000 4000 c000 0100 0200 0752f 38ad1 0
S ffff 0064 0abc 0def 0000 7fff 9000 1000 3ffff 00064 0
# Complex weights on all channels
W 0 4000 2000
W 1 e000 4000
W 2 2000 c000
W 3 c000 e000
C
S 03e8 f830 f447 01f5 0007 fff3 f060 e890 007cb 00651 0
S b1e0 2ee0 3a98 d8f1 ffff 0001 0003 0005 3d21a 02af6 0
# Shadow writes, old set holds until the commit
R 0
W 0 0000 4000
S 03e8 f830 f447 01f5 0007 fff3 f060 e890 007cb 00651 0
W 1 0000 0000
W 2 0000 0000
W 3 4000 0000
S b1e0 2ee0 3a98 d8f1 ffff 0001 0003 0005 3d21a 02af6 0
C
S 03e8 f830 f447 01f5 0007 fff3 f060 e890 3fc18 3f63c 0
# Back to back burst
S b1e0 2ee0 3a98 d8f1 ffff 0001 0003 0005 3e892 3d8f3 0
S 03e8 f830 f447 01f5 0007 fff3 f060 e890 3fc18 3f63c 0
S b1e0 2ee0 3a98 d8f1 ffff 0001 0003 0005 3e892 3d8f3 0
I 4
# Same samples with random gaps
R 1
S 03e8 f830 f447 01f5 0007 fff3 f060 e890 3fc18 3f63c 0
S b1e0 2ee0 3a98 d8f1 ffff 0001 0003 0005 3e892 3d8f3 0
# Weight -1 on channels 0 and 3, extreme products
W 0 8000 0000
W 3 8000 0000
C
S 8000 0000 1111 2222 3333 4444 0000 0000 38000 00000 1
S 8001 0000 1111 2222 3333 4444 0001 0000 07ffe 00000 0
S 0000 0000 5555 6666 7777 1234 0000 8000 00000 38000 1
S 4000 c000 5555 6666 7777 1234 c000 c000 00000 08000 0
S 8000 8000 0000 0000 0000 0000 8000 0000 30000 38000 1
I 2
